//--- verilog/rvga_macros.svh
`ifndef RVGA_MACROS_SVH
`define RVGA_MACROS_SVH

// Integer word width.
`define RVGA_XLEN 32

// Data memory depth in words.
`define RVGA_DMEM_WORDS 256

// Destination register index width.
`define RVGA_REG_ADDR_W 5

`endif

//--- verilog/rvga_pkg.sv
`include "rvga_macros.svh"

package rvga_pkg;

  typedef logic [`RVGA_XLEN-1:0] rvga_word;

  // Byte and halfword lanes of one word.
  typedef union packed {
    logic [`RVGA_XLEN/8-1:0][7:0]   bytes;
    logic [`RVGA_XLEN/16-1:0][15:0] halves;
  } rvga_word_u;

  // Load and store size codes.
  typedef enum logic [2:0] {
    F3_B  = 3'd0,
    F3_H  = 3'd1,
    F3_W  = 3'd2,
    F3_BU = 3'd4,
    F3_HU = 3'd5
  } rvga_funct3;

  // All zero is a bubble.
  typedef struct packed {
    logic       dmem_r_v;
    logic       dmem_w_v;
    logic       br_v;
    logic       jmp_v;
    logic       reg_w_v;
    rvga_funct3 funct3;
  } rvga_cword;

  typedef struct packed {
    rvga_word                    pc;
    logic [`RVGA_REG_ADDR_W-1:0] rd_addr;
  } rvga_dword;

endpackage : rvga_pkg

//--- verilog/rvga_dmem_if.sv
`timescale 1ns/1ps
`include "rvga_macros.svh"

interface rvga_dmem_if;

  logic                     r_v;
  logic                     w_v;
  rvga_pkg::rvga_word       addr;
  // Store data already sits in its byte lanes.
  rvga_pkg::rvga_word       wdata;
  logic [`RVGA_XLEN/8-1:0]  wmask;
  rvga_pkg::rvga_word       rdata;

  modport stage (
    output r_v, w_v, addr, wdata, wmask,
    input  rdata
  );

  modport mem (
    input  r_v, w_v, addr, wdata, wmask,
    output rdata
  );

endinterface : rvga_dmem_if

//--- verilog/memory_slicer.sv
`timescale 1ns/1ps
`include "rvga_macros.svh"

module memory_slicer (
  input  logic                    clk_i
  , input  logic                    mem_v_i
  , input  rvga_pkg::rvga_funct3    op_i
  , input  logic [1:0]              byte_off_i
  , input  rvga_pkg::rvga_word      st_data_i
  , input  rvga_pkg::rvga_word      ld_data_i
  , output rvga_pkg::rvga_word      st_data_o
  , output logic [`RVGA_XLEN/8-1:0] st_mask_o
  , output rvga_pkg::rvga_word      ld_result_o
);

  rvga_pkg::rvga_word_u st_in;
  rvga_pkg::rvga_word_u st_out;
  rvga_pkg::rvga_word_u ld_in;
  logic [7:0]           ld_byte;
  logic [15:0]          ld_half;

  // Store lane placement.
  always_comb begin
    st_in     = st_data_i;
    st_out    = '0;
    st_mask_o = '0;
    case (op_i)
      rvga_pkg::F3_B, rvga_pkg::F3_BU: begin
        st_out.bytes[byte_off_i] = st_in.bytes[0];
        st_mask_o[byte_off_i]    = 1'b1;
      end
      rvga_pkg::F3_H, rvga_pkg::F3_HU: begin
        st_out.halves[byte_off_i[1]] = st_in.halves[0];
        st_mask_o = byte_off_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        st_out    = st_in;
        st_mask_o = '1;
      end
    endcase
    st_data_o = st_out;
  end

  // Load lane pick and extension.
  always_comb begin
    ld_in   = ld_data_i;
    ld_byte = ld_in.bytes[byte_off_i];
    ld_half = ld_in.halves[byte_off_i[1]];
    case (op_i)
      rvga_pkg::F3_B:  ld_result_o = {{(`RVGA_XLEN-8){ld_byte[7]}}, ld_byte};
      rvga_pkg::F3_BU: ld_result_o = {{(`RVGA_XLEN-8){1'b0}}, ld_byte};
      rvga_pkg::F3_H:  ld_result_o = {{(`RVGA_XLEN-16){ld_half[15]}}, ld_half};
      rvga_pkg::F3_HU: ld_result_o = {{(`RVGA_XLEN-16){1'b0}}, ld_half};
      default:         ld_result_o = ld_in;
    endcase
  end

  // Accesses are always naturally aligned.
  a_aligned : assert property (@(posedge clk_i)
    mem_v_i |-> ((op_i inside {rvga_pkg::F3_H, rvga_pkg::F3_HU}) ? !byte_off_i[0] :
                 (op_i == rvga_pkg::F3_W) ? (byte_off_i == 2'b00) : 1'b1));

endmodule : memory_slicer

//--- verilog/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                 clk_i
  , input  logic                 rst_n_i
  , input  logic                 stall_i
  , input  rvga_pkg::rvga_cword  cword_i
  , input  rvga_pkg::rvga_dword  dword_i
  , input  rvga_pkg::rvga_word   alu_result_i
  , input  rvga_pkg::rvga_word   st_data_i
  , input  logic                 bru_result_i
  , rvga_dmem_if.stage           dmem
  , output rvga_pkg::rvga_cword  cword_o
  , output rvga_pkg::rvga_dword  dword_o
  , output rvga_pkg::rvga_word   result_o
  , output logic                 btaken_o
  , output logic                 br_v_o
);

  rvga_pkg::rvga_cword cword_r;
  rvga_pkg::rvga_dword dword_r;
  rvga_pkg::rvga_word  alu_result_r;
  rvga_pkg::rvga_word  st_data_r;
  rvga_pkg::rvga_word  ld_result;
  logic                mem_v;

  // Stage registers hold while stalled.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cword_r      <= '0;
      dword_r      <= '0;
      alu_result_r <= '0;
      st_data_r    <= '0;
    end else if (!stall_i) begin
      cword_r      <= cword_i;
      dword_r      <= dword_i;
      alu_result_r <= alu_result_i;
      st_data_r    <= st_data_i;
    end
  end

  assign mem_v = cword_r.dmem_r_v | cword_r.dmem_w_v;

  memory_slicer i_memory_slicer (
    .clk_i       (clk_i),
    .mem_v_i     (mem_v),
    .op_i        (cword_r.funct3),
    .byte_off_i  (alu_result_r[1:0]),
    .st_data_i   (st_data_r),
    .ld_data_i   (dmem.rdata),
    .st_data_o   (dmem.wdata),
    .st_mask_o   (dmem.wmask),
    .ld_result_o (ld_result)
  );

  // Request strobes come straight from the registered word.
  assign dmem.r_v  = cword_r.dmem_r_v;
  assign dmem.w_v  = cword_r.dmem_w_v;
  assign dmem.addr = alu_result_r;

  assign result_o = cword_r.dmem_r_v ? ld_result : alu_result_r;

  assign btaken_o = cword_r.jmp_v | (cword_r.br_v & bru_result_i);
  assign br_v_o   = cword_r.jmp_v | cword_r.br_v;

  assign cword_o = cword_r;
  assign dword_o = dword_r;

  a_no_rw : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(cword_r.dmem_r_v && cword_r.dmem_w_v));

endmodule : memory_stage

//--- verilog/data_memory.sv
`timescale 1ns/1ps
`include "rvga_macros.svh"

module data_memory (
  input  logic     clk_i
  , rvga_dmem_if.mem dmem
);

  localparam int unsigned IDX_W   = $clog2(`RVGA_DMEM_WORDS);
  localparam int unsigned N_BYTES = `RVGA_XLEN / 8;

  rvga_pkg::rvga_word mem_q [`RVGA_DMEM_WORDS] = '{default: '0};
  logic [IDX_W-1:0]   word_idx;

  // Byte address down to word index.
  assign word_idx = dmem.addr[2 +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (dmem.w_v) begin
      for (int b = 0; b < N_BYTES; b++) begin
        if (dmem.wmask[b]) begin
          mem_q[word_idx][8*b +: 8] <= dmem.wdata[8*b +: 8];
        end
      end
    end
  end

  assign dmem.rdata = mem_q[word_idx];

  a_wmask : assert property (@(posedge clk_i)
    dmem.w_v |-> (|dmem.wmask));

  // Upper address bits are ignored, so flag aliasing.
  a_in_range : assert property (@(posedge clk_i)
    (dmem.r_v || dmem.w_v) |-> (dmem.addr < `RVGA_DMEM_WORDS * N_BYTES));

endmodule : data_memory

//--- verilog/rvga_mem_subsys.sv
`timescale 1ns/1ps
`include "rvga_macros.svh"

module rvga_mem_subsys (
  input  logic                        clk_i
  , input  logic                        rst_n_i
  , input  logic                        stall_i
  , input  logic                        ld_v_i
  , input  logic                        st_v_i
  , input  logic                        br_v_i
  , input  logic                        jmp_v_i
  , input  logic                        reg_w_v_i
  , input  logic [2:0]                  funct3_i
  , input  logic [`RVGA_REG_ADDR_W-1:0] rd_addr_i
  , input  logic [`RVGA_XLEN-1:0]       pc_i
  , input  logic [`RVGA_XLEN-1:0]       alu_result_i
  , input  logic [`RVGA_XLEN-1:0]       st_data_i
  , input  logic                        bru_result_i
  , output logic [`RVGA_XLEN-1:0]       result_o
  , output logic                        btaken_o
  , output logic                        br_v_o
  , output logic                        wb_v_o
  , output logic [`RVGA_REG_ADDR_W-1:0] rd_addr_o
  , output logic [`RVGA_XLEN-1:0]       pc_o
);

  rvga_pkg::rvga_cword cword_in;
  rvga_pkg::rvga_dword dword_in;
  rvga_pkg::rvga_cword cword_out;
  rvga_pkg::rvga_dword dword_out;

  rvga_dmem_if dmem_if ();

  assign cword_in = '{
    dmem_r_v: ld_v_i,
    dmem_w_v: st_v_i,
    br_v:     br_v_i,
    jmp_v:    jmp_v_i,
    reg_w_v:  reg_w_v_i,
    funct3:   rvga_pkg::rvga_funct3'(funct3_i)
  };

  assign dword_in = '{pc: pc_i, rd_addr: rd_addr_i};

  memory_stage i_memory_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .cword_i      (cword_in),
    .dword_i      (dword_in),
    .alu_result_i (alu_result_i),
    .st_data_i    (st_data_i),
    .bru_result_i (bru_result_i),
    .dmem         (dmem_if.stage),
    .cword_o      (cword_out),
    .dword_o      (dword_out),
    .result_o     (result_o),
    .btaken_o     (btaken_o),
    .br_v_o       (br_v_o)
  );

  data_memory i_data_memory (
    .clk_i (clk_i),
    .dmem  (dmem_if.mem)
  );

  assign wb_v_o    = cword_out.reg_w_v;
  assign rd_addr_o = dword_out.rd_addr;
  assign pc_o      = dword_out.pc;

endmodule : rvga_mem_subsys

//--- tests/mem_checker.sv
`timescale 1ns/1ps
`include "rvga_macros.svh"

module mem_checker (
  input  logic                        clk_i
  , input  logic                        rst_n_i
  , input  logic                        stall_i
  , input  logic                        ld_v_i
  , input  logic                        st_v_i
  , input  logic                        br_v_i
  , input  logic                        jmp_v_i
  , input  logic                        reg_w_v_i
  , input  logic [2:0]                  funct3_i
  , input  logic [`RVGA_REG_ADDR_W-1:0] rd_addr_i
  , input  logic [`RVGA_XLEN-1:0]       pc_i
  , input  logic [`RVGA_XLEN-1:0]       alu_result_i
  , input  logic [`RVGA_XLEN-1:0]       st_data_i
  , input  logic                        bru_result_i
  , input  logic [`RVGA_XLEN-1:0]       dut_result_i
  , input  logic                        dut_btaken_i
  , input  logic                        dut_br_v_i
  , input  logic                        dut_wb_v_i
  , input  logic [`RVGA_REG_ADDR_W-1:0] dut_rd_addr_i
  , input  logic [`RVGA_XLEN-1:0]       dut_pc_i
  , output logic                        ready_o
  , output int                          err_cnt_o
  , output int                          chk_cnt_o
);

  logic [7:0] ref_mem [0:4*`RVGA_DMEM_WORDS-1];

  // Instruction currently held in the stage.
  logic                        h_ld, h_st, h_br, h_jmp, h_wb;
  logic [2:0]                  h_f3;
  logic [`RVGA_REG_ADDR_W-1:0] h_rd;
  logic [`RVGA_XLEN-1:0]       h_pc, h_alu, h_sd;

  initial begin
    for (int i = 0; i < 4*`RVGA_DMEM_WORDS; i++) begin
      ref_mem[i] = 8'h00;
    end
    {h_ld, h_st, h_br, h_jmp, h_wb, h_f3, h_rd, h_pc, h_alu, h_sd} = '0;
    ready_o   = 1'b0;
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

  function automatic int unsigned access_bytes(input logic [2:0] f3);
    case (f3[1:0])
      2'd0:    return 1;
      2'd1:    return 2;
      default: return 4;
    endcase
  endfunction

  function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [31:0] addr);
    logic [31:0] raw;
    int unsigned n;
    int unsigned base;
    raw  = '0;
    n    = access_bytes(f3);
    base = addr[9:0];
    for (int i = 0; i < n; i++) begin
      raw[8*i +: 8] = ref_mem[base + i];
    end
    // Signed loads copy the top bit of the loaded value.
    if (!f3[2] && n == 1 && raw[7]) raw[31:8] = '1;
    if (!f3[2] && n == 2 && raw[15]) raw[31:16] = '1;
    return raw;
  endfunction

  task automatic store_bytes(input logic [2:0] f3, input logic [31:0] addr,
                             input logic [31:0] data);
    int unsigned base;
    base = addr[9:0];
    for (int i = 0; i < access_bytes(f3); i++) begin
      ref_mem[base + i] = data[8*i +: 8];
    end
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt_o++;
    if (act !== exp) begin
      err_cnt_o++;
      $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // Outputs still show the held instruction at the edge.
  always @(posedge clk_i) begin
    if (ready_o) begin
      compare("btaken_o", h_jmp | (h_br & bru_result_i), dut_btaken_i);
      compare("br_v_o", h_jmp | h_br, dut_br_v_i);
      compare("wb_v_o", h_wb, dut_wb_v_i);
      compare("rd_addr_o", h_rd, dut_rd_addr_i);
      compare("pc_o", h_pc, dut_pc_i);
      compare("result_o", h_ld ? expect_load(h_f3, h_alu) : h_alu, dut_result_i);
    end
    if (h_st) store_bytes(h_f3, h_alu, h_sd);
    if (!rst_n_i) begin
      {h_ld, h_st, h_br, h_jmp, h_wb, h_f3, h_rd, h_pc, h_alu, h_sd} = '0;
      ready_o = 1'b1;
    end else if (!stall_i) begin
      {h_ld, h_st, h_br, h_jmp, h_wb} = {ld_v_i, st_v_i, br_v_i, jmp_v_i, reg_w_v_i};
      {h_f3, h_rd, h_pc} = {funct3_i, rd_addr_i, pc_i};
      {h_alu, h_sd} = {alu_result_i, st_data_i};
    end
  end

endmodule : mem_checker

//--- tests/tb_mem_subsys.sv
`timescale 1ns/1ps
`include "rvga_macros.svh"

module tb_mem_subsys;

  logic clk_i, rst_n_i, stall_i, bru_result_i;
  logic ld_v_i, st_v_i, br_v_i, jmp_v_i, reg_w_v_i;
  logic [2:0] funct3_i;
  logic [`RVGA_REG_ADDR_W-1:0] rd_addr_i, rd_addr_o;
  logic [`RVGA_XLEN-1:0] pc_i, alu_result_i, st_data_i, result_o, pc_o;
  logic btaken_o, br_v_o, wb_v_o, chk_ready;
  int err_cnt, chk_cnt;
  logic [2:0] codes [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

  rvga_mem_subsys i_rvga_mem_subsys (.*);

  mem_checker i_mem_checker (
    .dut_result_i (result_o), .dut_btaken_i (btaken_o), .dut_br_v_i (br_v_o),
    .dut_wb_v_i (wb_v_o), .dut_rd_addr_i (rd_addr_o), .dut_pc_i (pc_o),
    .ready_o (chk_ready), .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt), .*
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Kind 0 is a bubble, 1 a load, 2 a store, 3 an ALU op and 4 a branch or jump.
  task automatic drive_instr(input int unsigned kind);
    logic [2:0] f3;
    logic [5:0] widx;
    logic [1:0] off;
    f3   = codes[$urandom_range(4)];
    widx = $urandom_range(63);
    {ld_v_i, st_v_i, br_v_i, jmp_v_i, reg_w_v_i} = '0;
    rd_addr_i    = $urandom;
    pc_i         = $urandom & 32'hffff_fffc;
    alu_result_i = $urandom;
    st_data_i    = $urandom;
    bru_result_i = $urandom_range(1);
    if (kind == 2) f3[2] = 1'b0;
    funct3_i = f3;
    case (kind)
      1, 2: begin
        ld_v_i    = (kind == 1);
        st_v_i    = (kind == 2);
        reg_w_v_i = (kind == 1);
        // Offset aligned to the access size.
        off          = $urandom_range(3) & {~f3[1], ~f3[1] & ~f3[0]};
        alu_result_i = {24'd0, widx, off};
      end
      3: reg_w_v_i = 1'b1;
      4: begin
        br_v_i    = $urandom_range(1);
        jmp_v_i   = $urandom_range(1);
        reg_w_v_i = jmp_v_i;
      end
      default: ;
    endcase
  endtask

  task automatic run_test(input string name, input int unsigned kmin, input int unsigned kmax,
                          input int unsigned n, input bit use_stall);
    int err0, chk0;
    int unsigned stall_left;
    err0       = err_cnt;
    chk0       = chk_cnt;
    stall_left = 0;
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      if (use_stall) begin
        if (stall_left == 0 && $urandom_range(3) == 0) stall_left = $urandom_range(6, 1);
        stall_i = (stall_left != 0);
        if (stall_left != 0) stall_left--;
      end
      drive_instr($urandom_range(kmax, kmin));
    end
    @(negedge clk_i);
    stall_i = 1'b0;
    drive_instr(0);
    repeat (2) @(negedge clk_i);
    $display("test %s: %0d checks, %0d errors", name, chk_cnt - chk0, err_cnt - err0);
  endtask

  initial begin
    int unsigned timeout;
    void'($urandom(35804));
    {rst_n_i, stall_i, bru_result_i, ld_v_i, st_v_i, br_v_i, jmp_v_i, reg_w_v_i} = '0;
    {funct3_i, rd_addr_i, pc_i, alu_result_i, st_data_i} = '0;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
    end
    rst_n_i = 1'b1;
    timeout = 0;
    while (!chk_ready && timeout < 10) begin
      @(negedge clk_i);
      timeout++;
    end
    if (!chk_ready) begin
      $display("checker never saw the reset, giving up");
      $display("** FAIL **");
      $finish;
    end else begin
      run_test("reset", 0, 0, 8, 1'b0);
      run_test("load_store", 1, 2, 400, 1'b0);
      run_test("alu_writeback", 3, 3, 100, 1'b0);
      run_test("branch", 4, 4, 100, 1'b0);
      run_test("stall", 0, 4, 400, 1'b1);
      $display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt > 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule : tb_mem_subsys

//--- src.f
+incdir+verilog
verilog/rvga_pkg.sv
verilog/rvga_dmem_if.sv
verilog/memory_slicer.sv
verilog/memory_stage.sv
verilog/data_memory.sv
verilog/rvga_mem_subsys.sv
tests/mem_checker.sv
tests/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: rvga_mem_subsys

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/rvga_pkg.sv
      - verilog/rvga_dmem_if.sv
      - verilog/memory_slicer.sv
      - verilog/memory_stage.sv
      - verilog/data_memory.sv
      - verilog/rvga_mem_subsys.sv
  - target: test
    files:
      - tests/mem_checker.sv
      - tests/tb_mem_subsys.sv
